/* include/prefetch_settings.svh */
`ifndef PREFETCH_SETTINGS_SVH
`define PREFETCH_SETTINGS_SVH

// Instruction words the fetch buffer can hold
// Bounds in-flight plus buffered fetches, valid range 2 to 8
`define PF_DEPTH 3

// Counter width, wide enough to hold PF_DEPTH itself
`define PF_CNT_W ($clog2(`PF_DEPTH + 1))

// Privilege used by the prefetcher until the first branch
`define PF_RESET_PRIV prefetch_pkg::PRIV_LVL_M

`endif

/* verilog/prefetch_pkg.sv */
package prefetch_pkg;

  ////////////////////
  // Privilege levels
  ////////////////////

  // Encoding follows the usual RISC-V mstatus.MPP values
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11
  } privlvl_t;

  ////////////////////
  // Prefetcher FSM
  ////////////////////

  // IDLE passes branch targets or incremented addresses
  // BRANCH_WAIT replays a branch target until the bus takes it
  typedef enum logic {
    IDLE        = 1'b0,
    BRANCH_WAIT = 1'b1
  } prefetch_state_e;

endpackage

/* verilog/prefetcher.sv */
`include "prefetch_settings.svh"

module prefetcher
(
  input  logic                  clk,
  input  logic                  rst_n,

  // Fetch buffer side
  input  logic                  fetch_branch_i,
  input  logic [31:0]           fetch_branch_addr_i,
  input  logic                  fetch_valid_i,
  output logic                  fetch_ready_o,
  input  logic                  fetch_ptr_access_i,
  output logic                  fetch_ptr_access_o,
  input  prefetch_pkg::privlvl_t fetch_priv_lvl_access_i,
  output prefetch_pkg::privlvl_t fetch_priv_lvl_access_o,

  // Bus request channel
  output logic                  trans_valid_o,
  input  logic                  trans_ready_i,
  output logic [31:0]           trans_addr_o,
  output logic                  trans_ptr_o
);

  import prefetch_pkg::*;

  prefetch_state_e state_q;
  prefetch_state_e state_nxt;

  // Attributes of the last branch or accepted request
  logic [31:0] trans_addr_q;
  logic [31:0] trans_addr_incr;
  logic        trans_ptr_q;
  privlvl_t    trans_priv_q;

  // Request accepted by the bus this cycle
  logic        trans_accept;

  // Next sequential word
  assign trans_addr_incr = trans_addr_q + 32'd4;

  // The fetch buffer alone decides when a request is wanted
  assign trans_valid_o = fetch_valid_i;
  assign trans_accept  = trans_valid_o && trans_ready_i;
  assign fetch_ready_o = trans_accept;

  // Pointer flag travels with the request
  assign trans_ptr_o = fetch_ptr_access_o;

  ////////////////////
  // Address FSM
  ////////////////////

  always_comb
  begin
    state_nxt               = state_q;
    trans_addr_o            = trans_addr_q;
    fetch_ptr_access_o      = trans_ptr_q;
    fetch_priv_lvl_access_o = trans_priv_q;

    case (state_q)
      IDLE:
      begin
        if (fetch_branch_i)
        begin
          // New stream starts at the branch target
          trans_addr_o            = fetch_branch_addr_i;
          fetch_ptr_access_o      = fetch_ptr_access_i;
          fetch_priv_lvl_access_o = fetch_priv_lvl_access_i;
          // Keep the target until the bus accepts it
          if (!trans_accept)
          begin
            state_nxt = BRANCH_WAIT;
          end
        end
        else
        begin
          // Sequential fetch, never a pointer access
          trans_addr_o            = trans_addr_incr;
          fetch_ptr_access_o      = 1'b0;
          fetch_priv_lvl_access_o = fetch_priv_lvl_access_i;
        end
      end

      BRANCH_WAIT:
      begin
        // Replay the stored target, a newer branch takes its place
        if (fetch_branch_i)
        begin
          trans_addr_o            = fetch_branch_addr_i;
          fetch_ptr_access_o      = fetch_ptr_access_i;
          fetch_priv_lvl_access_o = fetch_priv_lvl_access_i;
        end
        // Target taken, back to sequential prefetch
        if (trans_accept)
        begin
          state_nxt = IDLE;
        end
      end

      default:
      begin
        state_nxt = IDLE;
      end
    endcase
  end

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q      <= IDLE;
      trans_addr_q <= '0;
      trans_ptr_q  <= 1'b0;
      trans_priv_q <= `PF_RESET_PRIV;
    end
    else
    begin
      state_q <= state_nxt;
      // Capture on a branch or once the bus takes the request
      if (fetch_branch_i || trans_accept)
      begin
        trans_addr_q <= trans_addr_o;
        trans_ptr_q  <= fetch_ptr_access_o;
        trans_priv_q <= fetch_priv_lvl_access_o;
      end
    end
  end

endmodule

/* verilog/fetch_buffer.sv */
`include "prefetch_settings.svh"

module fetch_buffer
(
  input  logic                   clk,
  input  logic                   rst_n,

  // Branch from the core
  input  logic                   branch_i,
  input  logic [31:0]            branch_addr_i,
  input  logic                   branch_ptr_i,
  input  prefetch_pkg::privlvl_t branch_priv_i,

  // Instructions to the core
  output logic                   instr_valid_o,
  input  logic                   instr_ready_i,
  output logic [31:0]            instr_rdata_o,
  output logic [31:0]            instr_addr_o,
  output logic                   instr_ptr_o,
  output prefetch_pkg::privlvl_t instr_priv_o,

  // Prefetcher control
  output logic                   fetch_valid_o,
  output logic                   fetch_branch_o,
  output logic [31:0]            fetch_branch_addr_o,
  output logic                   fetch_ptr_access_o,
  output prefetch_pkg::privlvl_t fetch_priv_lvl_access_o,
  input  logic                   fetch_ready_i,
  input  logic                   fetch_ptr_access_ret_i,
  input  prefetch_pkg::privlvl_t fetch_priv_ret_i,

  // Bus responses, in request order
  input  logic                   resp_valid_i,
  input  logic [31:0]            resp_rdata_i
);

  import prefetch_pkg::*;

  localparam int DEPTH = `PF_DEPTH;
  localparam int CNT_W = `PF_CNT_W;
  localparam int PTR_W = $clog2(DEPTH);

  // Wrap a queue index at DEPTH
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    nxt = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    return nxt;
  endfunction

  // Control state
  logic             active_q;
  privlvl_t         priv_q;
  logic [CNT_W-1:0] out_cnt_q;
  logic [CNT_W-1:0] disc_cnt_q;
  logic [CNT_W-1:0] fifo_cnt_q;
  logic [CNT_W:0]   room_sum;
  logic             resp_keep;
  logic             instr_pop;
  logic [31:0]      pc_q;

  // Attribute queue, one entry per accepted request
  logic             attr_ptr_q  [DEPTH];
  privlvl_t         attr_priv_q [DEPTH];
  logic [PTR_W-1:0] attr_wr_q;
  logic [PTR_W-1:0] attr_rd_q;
  logic [PTR_W-1:0] attr_wr_idx;

  // Instruction FIFO
  logic [31:0]      fifo_data_q [DEPTH];
  logic [31:0]      fifo_addr_q [DEPTH];
  logic             fifo_ptr_q  [DEPTH];
  privlvl_t         fifo_priv_q [DEPTH];
  logic [PTR_W-1:0] fifo_wr_q;
  logic [PTR_W-1:0] fifo_rd_q;

  ////////////////////
  // Request control
  ////////////////////

  // Branch info goes straight to the prefetcher
  assign fetch_branch_o      = branch_i;
  assign fetch_branch_addr_o = branch_addr_i;
  assign fetch_ptr_access_o  = branch_ptr_i;
  assign fetch_priv_lvl_access_o = branch_i ? branch_priv_i : priv_q;

  // FIFO is empty from the next cycle on a branch
  assign room_sum = {1'b0, out_cnt_q} + (branch_i ? '0 : {1'b0, fifo_cnt_q});

  // In-flight, discarded ones included, plus buffered stays within DEPTH
  assign fetch_valid_o = (branch_i || active_q) && (room_sum < (CNT_W + 1)'(DEPTH));

  // Old-stream responses are dropped, also the one arriving with a branch
  assign resp_keep = resp_valid_i && (disc_cnt_q == '0) && !branch_i;

  // No stale instruction moves in the branch cycle
  assign instr_valid_o = (fifo_cnt_q != '0) && !branch_i;
  assign instr_pop     = instr_valid_o && instr_ready_i;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      active_q   <= 1'b0;
      priv_q     <= `PF_RESET_PRIV;
      out_cnt_q  <= '0;
      disc_cnt_q <= '0;
      pc_q       <= '0;
    end
    else
    begin
      // Bus transactions not yet answered
      if (fetch_ready_i && !resp_valid_i)
      begin
        out_cnt_q <= out_cnt_q + 1'b1;
      end
      else if (!fetch_ready_i && resp_valid_i)
      begin
        out_cnt_q <= out_cnt_q - 1'b1;
      end

      if (branch_i)
      begin
        active_q   <= 1'b1;
        priv_q     <= branch_priv_i;
        pc_q       <= branch_addr_i;
        // Everything still in flight belongs to the old stream
        disc_cnt_q <= out_cnt_q - CNT_W'(resp_valid_i);
      end
      else
      begin
        if (resp_valid_i && (disc_cnt_q != '0))
        begin
          disc_cnt_q <= disc_cnt_q - 1'b1;
        end
        // Address of the next kept word
        if (resp_keep)
        begin
          pc_q <= pc_q + 32'd4;
        end
      end
    end
  end

  ////////////////////
  // Attribute queue
  ////////////////////

  // Cleared on a branch, the new target may land in slot 0 at once
  assign attr_wr_idx = branch_i ? '0 : attr_wr_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      attr_wr_q <= '0;
      attr_rd_q <= '0;
    end
    else
    begin
      if (fetch_ready_i)
      begin
        attr_wr_q <= ptr_next(attr_wr_idx);
      end
      else if (branch_i)
      begin
        attr_wr_q <= '0;
      end
      if (branch_i)
      begin
        attr_rd_q <= '0;
      end
      else if (resp_keep)
      begin
        attr_rd_q <= ptr_next(attr_rd_q);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (fetch_ready_i)
    begin
      attr_ptr_q[attr_wr_idx]  <= fetch_ptr_access_ret_i;
      attr_priv_q[attr_wr_idx] <= fetch_priv_ret_i;
    end
  end

  ////////////////////
  // Instruction FIFO
  ////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      fifo_wr_q  <= '0;
      fifo_rd_q  <= '0;
      fifo_cnt_q <= '0;
    end
    else if (branch_i)
    begin
      // Flush, nothing is pushed or popped this cycle
      fifo_wr_q  <= '0;
      fifo_rd_q  <= '0;
      fifo_cnt_q <= '0;
    end
    else
    begin
      if (resp_keep)
      begin
        fifo_wr_q <= ptr_next(fifo_wr_q);
      end
      if (instr_pop)
      begin
        fifo_rd_q <= ptr_next(fifo_rd_q);
      end
      if (resp_keep && !instr_pop)
      begin
        fifo_cnt_q <= fifo_cnt_q + 1'b1;
      end
      else if (!resp_keep && instr_pop)
      begin
        fifo_cnt_q <= fifo_cnt_q - 1'b1;
      end
    end
  end

  // Kept word joins its request attributes and running PC
  always_ff @(posedge clk)
  begin
    if (resp_keep)
    begin
      fifo_data_q[fifo_wr_q] <= resp_rdata_i;
      fifo_addr_q[fifo_wr_q] <= pc_q;
      fifo_ptr_q[fifo_wr_q]  <= attr_ptr_q[attr_rd_q];
      fifo_priv_q[fifo_wr_q] <= attr_priv_q[attr_rd_q];
    end
  end

  assign instr_rdata_o = fifo_data_q[fifo_rd_q];
  assign instr_addr_o  = fifo_addr_q[fifo_rd_q];
  assign instr_ptr_o   = fifo_ptr_q[fifo_rd_q];
  assign instr_priv_o  = fifo_priv_q[fifo_rd_q];

endmodule

/* verilog/prefetch_unit.sv */
module prefetch_unit
(
  input  logic                   clk,
  input  logic                   rst_n,

  // Core side, branches
  input  logic                   branch_i,
  input  logic [31:0]            branch_addr_i,
  input  logic                   branch_ptr_i,
  input  prefetch_pkg::privlvl_t branch_priv_i,

  // Core side, instructions
  output logic                   instr_valid_o,
  input  logic                   instr_ready_i,
  output logic [31:0]            instr_rdata_o,
  output logic [31:0]            instr_addr_o,
  output logic                   instr_ptr_o,
  output prefetch_pkg::privlvl_t instr_priv_o,

  // Bus request channel
  output logic                   trans_valid_o,
  input  logic                   trans_ready_i,
  output logic [31:0]            trans_addr_o,
  output logic                   trans_ptr_o,
  output prefetch_pkg::privlvl_t trans_priv_o,

  // Bus responses
  input  logic                   resp_valid_i,
  input  logic [31:0]            resp_rdata_i
);

  import prefetch_pkg::*;

  // Buffer to prefetcher
  logic        fetch_valid;
  logic        fetch_branch;
  logic [31:0] fetch_branch_addr;
  logic        fetch_ptr_access;
  privlvl_t    fetch_priv_lvl_access;

  // Prefetcher to buffer, attributes of the accepted request
  logic        fetch_ready;
  logic        fetch_ptr_access_out;
  privlvl_t    fetch_priv_out;

  fetch_buffer u_fetch_buffer
  (
    .clk                     (clk),
    .rst_n                   (rst_n),
    .branch_i                (branch_i),
    .branch_addr_i           (branch_addr_i),
    .branch_ptr_i            (branch_ptr_i),
    .branch_priv_i           (branch_priv_i),
    .instr_valid_o           (instr_valid_o),
    .instr_ready_i           (instr_ready_i),
    .instr_rdata_o           (instr_rdata_o),
    .instr_addr_o            (instr_addr_o),
    .instr_ptr_o             (instr_ptr_o),
    .instr_priv_o            (instr_priv_o),
    .fetch_valid_o           (fetch_valid),
    .fetch_branch_o          (fetch_branch),
    .fetch_branch_addr_o     (fetch_branch_addr),
    .fetch_ptr_access_o      (fetch_ptr_access),
    .fetch_priv_lvl_access_o (fetch_priv_lvl_access),
    .fetch_ready_i           (fetch_ready),
    .fetch_ptr_access_ret_i  (fetch_ptr_access_out),
    .fetch_priv_ret_i        (fetch_priv_out),
    .resp_valid_i            (resp_valid_i),
    .resp_rdata_i            (resp_rdata_i)
  );

  prefetcher u_prefetcher
  (
    .clk                     (clk),
    .rst_n                   (rst_n),
    .fetch_branch_i          (fetch_branch),
    .fetch_branch_addr_i     (fetch_branch_addr),
    .fetch_valid_i           (fetch_valid),
    .fetch_ready_o           (fetch_ready),
    .fetch_ptr_access_i      (fetch_ptr_access),
    .fetch_ptr_access_o      (fetch_ptr_access_out),
    .fetch_priv_lvl_access_i (fetch_priv_lvl_access),
    .fetch_priv_lvl_access_o (fetch_priv_out),
    .trans_valid_o           (trans_valid_o),
    .trans_ready_i           (trans_ready_i),
    .trans_addr_o            (trans_addr_o),
    .trans_ptr_o             (trans_ptr_o)
  );

  // Bus privilege is that of the request on the channel
  assign trans_priv_o = fetch_priv_out;

endmodule

/* bench/tb_prefetch_unit.sv */
`include "prefetch_settings.svh"

module tb_prefetch_unit;

  timeunit 1ns;
  timeprecision 100ps;

  import prefetch_pkg::*;

  // DUT ports
  logic        clk;
  logic        rst_n;
  logic        branch_i;
  logic [31:0] branch_addr_i;
  logic        branch_ptr_i;
  privlvl_t    branch_priv_i;
  logic        instr_valid_o;
  logic        instr_ready_i;
  logic [31:0] instr_rdata_o;
  logic [31:0] instr_addr_o;
  logic        instr_ptr_o;
  privlvl_t    instr_priv_o;
  logic        trans_valid_o;
  logic        trans_ready_i;
  logic [31:0] trans_addr_o;
  logic        trans_ptr_o;
  privlvl_t    trans_priv_o;
  logic        resp_valid_i;
  logic [31:0] resp_rdata_i;

  // Case table and run control
  logic [31:0] case_mem [0:127];
  int          n_cases;
  int          total_instr;
  int          cyc_limit;
  int          cyc;
  int          case_idx;
  int          base;
  int unsigned bus_stall;
  int unsigned cons_stall;

  // Bus memory model, in-order answers
  logic [31:0] mem_addr_q [$];
  int          mem_due_q [$];
  logic [31:0] resp_addr;

  // Scoreboard state for the current stream
  logic            started;
  logic [31:0]     exp_addr;
  logic [31:0]     exp_req;
  logic            first_instr;
  logic            first_req;
  logic            stream_ptr;
  privlvl_t        stream_priv;
  int              acc_stream;
  int              del_stream;
  int              checks;
  int              errors;
  prefetch_state_e pf_state;

  prefetch_unit dut_i
  (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .branch_ptr_i  (branch_ptr_i),
    .branch_priv_i (branch_priv_i),
    .instr_valid_o (instr_valid_o),
    .instr_ready_i (instr_ready_i),
    .instr_rdata_o (instr_rdata_o),
    .instr_addr_o  (instr_addr_o),
    .instr_ptr_o   (instr_ptr_o),
    .instr_priv_o  (instr_priv_o),
    .trans_valid_o (trans_valid_o),
    .trans_ready_i (trans_ready_i),
    .trans_addr_o  (trans_addr_o),
    .trans_ptr_o   (trans_ptr_o),
    .trans_priv_o  (trans_priv_o),
    .resp_valid_i  (resp_valid_i),
    .resp_rdata_i  (resp_rdata_i)
  );

  task automatic flag_error(input string msg);
    errors = errors + 1;
    $display("** Error @ %0t: %s", $time, msg);
  endtask

  // 4 ns clock
  always #2 clk = ~clk;

  ////////////////////
  // Bus and consumer drive
  ////////////////////

  always @(posedge clk)
  begin
    cyc = cyc + 1;
    if (rst_n)
    begin
      trans_ready_i <= (($urandom % 100) >= bus_stall);
      instr_ready_i <= (($urandom % 100) >= cons_stall);
      // Head of the queue answers once its delay is up
      if ((mem_due_q.size() > 0) && (mem_due_q[0] <= cyc))
      begin
        resp_addr = mem_addr_q.pop_front();
        void'(mem_due_q.pop_front());
        resp_valid_i <= 1'b1;
        resp_rdata_i <= resp_addr ^ 32'h5a5a_0000;
      end
      else
      begin
        resp_valid_i <= 1'b0;
      end
    end
  end

  ////////////////////
  // Monitor and scoreboard
  ////////////////////

  // Sampled mid-cycle, inputs only move on the rising edge
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (branch_i)
      begin
        // Very first branch must go out on the bus at once
        if (!started)
        begin
          checks = checks + 1;
          if (!trans_valid_o || (trans_addr_o != branch_addr_i))
            flag_error($sformatf("first request %b/%h, expected 1/%h",
                                 trans_valid_o, trans_addr_o, branch_addr_i));
        end
        started     = 1'b1;
        exp_addr    = branch_addr_i;
        exp_req     = branch_addr_i;
        first_instr = 1'b1;
        first_req   = 1'b1;
        stream_ptr  = branch_ptr_i;
        stream_priv = branch_priv_i;
        acc_stream  = 0;
        del_stream  = 0;
      end
      else if (!started)
      begin
        // Quiet until the first branch
        checks = checks + 1;
        if (trans_valid_o || instr_valid_o)
          flag_error("activity before the first branch");
        checks = checks + 1;
        if (trans_priv_o != `PF_RESET_PRIV)
          flag_error($sformatf("reset privilege %0d", trans_priv_o));
      end

      // Accepted request, same cycle as a branch belongs to the new stream
      if (trans_valid_o && trans_ready_i)
      begin
        pf_state = dut_i.u_prefetcher.state_q;
        checks = checks + 1;
        if ((trans_addr_o != exp_req) || (trans_ptr_o != (first_req && stream_ptr)) ||
            (trans_priv_o != stream_priv))
          flag_error($sformatf("request %h/%b/%0d, expected %h/%b/%0d, FSM %s",
                               trans_addr_o, trans_ptr_o, trans_priv_o, exp_req,
                               first_req && stream_ptr, stream_priv, pf_state.name()));
        mem_addr_q.push_back(trans_addr_o);
        mem_due_q.push_back(cyc + 1 + int'($urandom % 4));
        exp_req    = exp_req + 32'd4;
        first_req  = 1'b0;
        acc_stream = acc_stream + 1;
      end

      // Delivered instruction
      if (instr_valid_o && instr_ready_i)
      begin
        checks = checks + 1;
        if ((instr_addr_o != exp_addr) || (instr_rdata_o != (exp_addr ^ 32'h5a5a_0000)))
          flag_error($sformatf("instr %h data %h, expected %h data %h", instr_addr_o,
                               instr_rdata_o, exp_addr, exp_addr ^ 32'h5a5a_0000));
        checks = checks + 1;
        if ((instr_ptr_o != (first_instr && stream_ptr)) || (instr_priv_o != stream_priv))
          flag_error($sformatf("instr %h ptr %b priv %0d, expected %b and %0d", exp_addr,
                               instr_ptr_o, instr_priv_o, first_instr && stream_ptr,
                               stream_priv));
        exp_addr    = exp_addr + 32'd4;
        first_instr = 1'b0;
        del_stream  = del_stream + 1;
      end

      // In flight plus buffered stays within the buffer depth
      checks = checks + 1;
      if (((acc_stream - del_stream) > `PF_DEPTH) || (mem_addr_q.size() > `PF_DEPTH))
        flag_error($sformatf("occupancy %0d, in flight %0d, depth %0d",
                             acc_stream - del_stream, mem_addr_q.size(), `PF_DEPTH));
    end
  end

  ////////////////////
  // Watchdog
  ////////////////////

  initial
  begin
    while (cyc_limit == 0)
      @(posedge clk);
    while (cyc < cyc_limit)
      @(posedge clk);
    $display("Timeout: run still busy after %0d cycles, %0d errors so far", cyc, errors);
    $display("CHECKS FAILED");
    $finish;
  end

  ////////////////////
  // Stimulus
  ////////////////////

  initial
  begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    branch_i      = 1'b0;
    branch_addr_i = '0;
    branch_ptr_i  = 1'b0;
    branch_priv_i = PRIV_LVL_U;
    instr_ready_i = 1'b0;
    trans_ready_i = 1'b0;
    resp_valid_i  = 1'b0;
    resp_rdata_i  = '0;
    cyc           = 0;
    cyc_limit     = 0;
    bus_stall     = 0;
    cons_stall    = 0;
    started       = 1'b0;
    first_instr   = 1'b0;
    first_req     = 1'b0;
    exp_addr      = '0;
    exp_req       = '0;
    stream_ptr    = 1'b0;
    stream_priv   = PRIV_LVL_U;
    acc_stream    = 0;
    del_stream    = 0;
    checks        = 0;
    errors        = 0;
    void'($urandom(32'hf9c9_1fc1));

    $readmemh("bench/prefetch_cases.txt", case_mem);
    n_cases     = int'(case_mem[0]);
    total_instr = 0;
    for (case_idx = 0; case_idx < n_cases; case_idx = case_idx + 1)
      total_instr = total_instr + int'(case_mem[1 + 6 * case_idx + 3]);
    cyc_limit = 64 * total_instr + 200;

    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    // Idle window, checked for silence
    repeat (5) @(posedge clk);

    for (case_idx = 0; case_idx < n_cases; case_idx = case_idx + 1)
    begin
      base = 1 + 6 * case_idx;
      cons_stall    <= case_mem[base + 4];
      bus_stall     <= case_mem[base + 5];
      branch_i      <= 1'b1;
      branch_addr_i <= case_mem[base];
      branch_ptr_i  <= case_mem[base + 1][0];
      branch_priv_i <= privlvl_t'(case_mem[base + 2][1:0]);
      @(posedge clk);
      branch_i <= 1'b0;
      // Next branch lands while the old stream is still running
      while (del_stream < int'(case_mem[base + 3]))
        @(posedge clk);
    end

    repeat (20) @(posedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if ((errors == 0) && (checks > 0))
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

/* prefetch_unit.f */
+incdir+include
verilog/prefetch_pkg.sv
verilog/prefetcher.sv
verilog/fetch_buffer.sv
verilog/prefetch_unit.sv
bench/tb_prefetch_unit.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the prefetch unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_prefetch_unit -f prefetch_unit.f

sim_out=$(./obj_dir/Vtb_prefetch_unit)
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "ALL CHECKS PASSED"
then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

/* bench/prefetch_cases.txt */
// Word 0 is the number of cases, then one line of six hex words per case
// target ptr priv(0=U 1=S 3=M) instr_count consumer_stall_pct bus_stall_pct
00000008
// Clean stream, no stalls
00001000 1 3 00000010 00 00
// Light stalls on both sides
00002000 0 3 0000000c 14 1e
// Supervisor stream, consumer half stalled
00000ff0 1 1 00000014 32 00
// Heavy bus stall, branches land on held requests
00004000 0 0 00000008 00 50
// Long consumer stalls, FIFO stays full
00008000 1 3 00000018 5a 0a
// Mixed stalls
00003ffc 0 1 00000006 1e 3c
// Both sides mostly stalled
0000a000 1 0 00000010 50 50
// Back to the first region
00001000 0 3 0000000c 0a 0a
